// ==== Makefile ====
# Verilator build and run for zoom_mem_ctrl

VERILATOR ?= verilator
TOP       ?= zoom_mem_ctrl_tb
RTL_TOP   ?= zoom_mem_ctrl
FILELIST  ?= zoom_mem_ctrl.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/100ps

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/zoom_golden.txt ====
# name op zoom_alt addr_base(hex) access_count first_addr(hex) last_addr(hex) write_count
# one command per line, counts in decimal, addresses are 18-bit word addresses
single_read      1 0 12345 1      12345 12345 0
single_write     2 0 3abcd 1      3abcd 3abcd 1
zoom_in          3 0 00000 153600 04b00 257ff 76800
zoom_in_alt      3 1 00000 153600 17700 383ff 76800
zoom_out_by_two  5 0 00000 38400  00000 257af 19200
zoom_out_by_four 5 1 00000 9600   00000 23207 4800
unsupported_4    4 0 00000 0      00000 00000 0
unsupported_6    6 0 00000 0      00000 00000 0

// ==== dv/zoom_mem_ctrl_tb.sv ====
module zoom_mem_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_TESTS         = 16;
    localparam int CYCLES_PER_ACCESS = 12; // held cycles plus both handshakes, rounded up
    localparam int HOLD_CYCLES       = 3;  // slow req release after ack

    logic            clock = 1'b0;
    logic            reset;
    logic            req;
    logic [2:0]      operation;
    logic            zoom_alt;
    zoom_pkg::addr_t addr_base;
    logic            ack;
    zoom_pkg::addr_t mem_addr;
    logic            mem_write;
    logic            mem_busy;

    string names [MAX_TESTS];
    int    op_tab [MAX_TESTS];
    int    alt_tab [MAX_TESTS];
    int    base_tab [MAX_TESTS];
    int    exp_count [MAX_TESTS];
    int    exp_first [MAX_TESTS];
    int    exp_last [MAX_TESTS];
    int    exp_writes [MAX_TESTS];
    int    n_tests = 0;

    string       cur_name = "reset";
    int          errors = 0;
    int          checks = 0;
    longint      cycle_count = 0;
    longint      cycle_limit = 1000; // grows with each golden line
    int unsigned acc_total = 0;      // accesses seen on the memory port
    int unsigned write_total = 0;
    int unsigned test_mark = 0;      // acc_total when the current test started
    int unsigned write_mark = 0;
    int          first_addr = 0;
    int          last_addr = 0;
    int          busy_len = 0;
    logic        busy_prev = 1'b0;

    zoom_mem_ctrl DUT (
        .clock     (clock),
        .reset     (reset),
        .req       (req),
        .operation (operation),
        .zoom_alt  (zoom_alt),
        .addr_base (addr_base),
        .ack       (ack),
        .mem_addr  (mem_addr),
        .mem_write (mem_write),
        .mem_busy  (mem_busy)
    );

    always #4 clock = ~clock;

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            $display("FAIL %0s %0s: expected %0d, actual %0d", cur_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic load_golden();
        int    fd;
        string line;
        string nm;
        int    op, alt, base, cnt, first, last, wr, got;
        fd = $fopen("dv/zoom_golden.txt", "r");
        if (fd == 0) begin
            $display("golden file dv/zoom_golden.txt could not be opened");
            errors++;
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                if ($fgets(line, fd) == 0) break;
                if (line.len() < 2 || line[0] == "#") continue; // blank or column notes
                got = $sscanf(line, "%s %d %d %h %d %h %h %d",
                              nm, op, alt, base, cnt, first, last, wr);
                if (got != 8) begin
                    $display("golden line could not be parsed: %0s", line);
                    errors++;
                    continue;
                end
                names[n_tests]      = nm;
                op_tab[n_tests]     = op;
                alt_tab[n_tests]    = alt;
                base_tab[n_tests]   = base;
                exp_count[n_tests]  = cnt;
                exp_first[n_tests]  = first;
                exp_last[n_tests]   = last;
                exp_writes[n_tests] = wr;
                cycle_limit += longint'(cnt) * CYCLES_PER_ACCESS + HOLD_CYCLES + 20;
                n_tests++;
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int t);
        cur_name = names[t];
        @(negedge clock);
        test_mark  = acc_total;
        write_mark = write_total;
        operation  = 3'(op_tab[t]);
        zoom_alt   = (alt_tab[t] != 0);
        addr_base  = zoom_pkg::addr_t'(base_tab[t]);
        req        = 1'b1;
        @(negedge clock);
        while (!ack) @(negedge clock);
        check_value("mem_busy at ack", 0, int'(mem_busy));
        repeat (HOLD_CYCLES) begin
            @(negedge clock);
            check_value("ack held while req high", 1, int'(ack));
        end
        req = 1'b0;
        @(negedge clock);
        check_value("ack after req release", 0, int'(ack));
        check_value("access count", exp_count[t], int'(acc_total - test_mark));
        check_value("write count", exp_writes[t], int'(write_total - write_mark));
        if (exp_count[t] > 0) begin
            check_value("first address", exp_first[t], first_addr);
            check_value("last address", exp_last[t], last_addr);
        end
    endtask

    // access monitor on the memory port
    always @(posedge clock) begin
        if (reset) begin
            busy_prev = 1'b0;
            busy_len  = 0;
        end else begin
            checks++;
            assert (mem_busy || !mem_write) else begin
                $display("%0s: mem_write was high while mem_busy was low", cur_name);
                errors++;
            end
            if (mem_busy && !busy_prev) begin
                if (acc_total == test_mark) first_addr = int'(mem_addr);
                last_addr = int'(mem_addr);
                acc_total++;
                if (mem_write) write_total++;
                checks++;
                assert (!ack) else begin
                    $display("%0s: memory access started while ack was high", cur_name);
                    errors++;
                end
            end
            if (mem_busy) begin
                busy_len++;
            end else if (busy_prev) begin
                check_value("mem_busy cycles", int'(zoom_pkg::ACCESS_CYCLES), busy_len);
                busy_len = 0;
            end
            busy_prev = mem_busy;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT did not finish the tests", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        reset     = 1'b1;
        req       = 1'b0;
        operation = 3'd0;
        zoom_alt  = 1'b0;
        addr_base = '0;
        load_golden();
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_value("ack after reset", 0, int'(ack));
        check_value("mem_busy after reset", 0, int'(mem_busy));
        check_value("mem_write after reset", 0, int'(mem_write));
        for (int t = 0; t < n_tests; t++) run_test(t);
        $display("errors %0d, checks %0d, tests %0d", errors, checks, n_tests);
        if (errors == 0 && n_tests > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== hw/mem_access_timer.sv ====
module mem_access_timer (
    input  logic            clock,
    input  logic            reset,
    input  logic            acc_req,
    input  zoom_pkg::addr_t acc_addr,
    input  logic            acc_write,
    output logic            acc_ack,
    output zoom_pkg::addr_t mem_addr,
    output logic            mem_write,
    output logic            mem_busy
);

    logic [2:0] count;  // cycles the access has been held
    logic       launch;

    assign launch = acc_req && !mem_busy && !acc_ack;

    always_ff @(posedge clock) begin
        if (reset) begin
            acc_ack   <= 1'b0;
            mem_busy  <= 1'b0;
            mem_write <= 1'b0;
            count     <= '0;
        end else if (mem_busy) begin
            count <= count + 3'd1;
            if (count == zoom_pkg::ACCESS_CYCLES - 3'd1) begin
                mem_busy  <= 1'b0;
                mem_write <= 1'b0;
                acc_ack   <= 1'b1;
            end
        end else if (acc_ack) begin
            if (!acc_req) acc_ack <= 1'b0; // request released
        end else if (launch) begin
            mem_busy  <= 1'b1;
            mem_write <= acc_write;
            count     <= '0;
        end
    end

    always_ff @(posedge clock) begin
        if (launch) mem_addr <= acc_addr;
    end

    req_held_until_ack: assert property (@(posedge clock) disable iff (reset)
        acc_req && !acc_ack |=> acc_req);

endmodule

// ==== hw/zoom_addr_sequencer.sv ====
module zoom_addr_sequencer (
    input  logic               clock,
    input  logic               reset,
    input  logic               start,
    input  zoom_pkg::op_kind_e kind,
    input  logic               factor_four,
    input  zoom_pkg::addr_t    src_base,
    input  zoom_pkg::addr_t    dst_base,
    input  logic               acc_ack,
    output logic               acc_req,
    output zoom_pkg::addr_t    acc_addr,
    output logic               acc_write,
    output logic               finished
);

    typedef enum logic [2:0] {
        s_idle,
        s_issue,
        s_wait_hi,
        s_wait_lo,
        s_next
    } state_t;

    state_t           state;
    zoom_pkg::coord_t x;
    zoom_pkg::coord_t y;
    logic             phase;  // 0 read, 1 write
    zoom_pkg::coord_t last_x;
    zoom_pkg::coord_t last_y;
    zoom_pkg::coord_t org_x;
    zoom_pkg::coord_t org_y;
    logic [1:0]       shift;  // log2 of the decimation factor
    logic             last_pixel;
    zoom_pkg::addr_t  next_addr;

    // walk extent and destination origin of the active command
    always_comb begin
        if (kind == zoom_pkg::kind_zoom_in) begin
            last_x = zoom_pkg::IMG_WIDTH - 10'd1;
            last_y = zoom_pkg::IMG_HEIGHT - 10'd1;
            org_x  = '0;
            org_y  = '0;
        end else if (factor_four) begin
            last_x = zoom_pkg::WIN4_W - 10'd1;
            last_y = zoom_pkg::WIN4_H - 10'd1;
            org_x  = zoom_pkg::WIN4_X0;
            org_y  = zoom_pkg::WIN4_Y0;
        end else begin
            last_x = zoom_pkg::WIN2_W - 10'd1;
            last_y = zoom_pkg::WIN2_H - 10'd1;
            org_x  = zoom_pkg::WIN2_X0;
            org_y  = zoom_pkg::WIN2_Y0;
        end
        shift = factor_four ? 2'd2 : 2'd1;
    end

    assign last_pixel = (x == last_x) && (y == last_y);

    always_comb begin
        if (kind == zoom_pkg::kind_single) begin
            next_addr = src_base;
        end else if (phase) begin
            next_addr = dst_base
                      + zoom_pkg::addr_t'(y + org_y) * zoom_pkg::addr_t'(zoom_pkg::IMG_WIDTH)
                      + zoom_pkg::addr_t'(x + org_x);
        end else if (kind == zoom_pkg::kind_zoom_in) begin
            next_addr = src_base // nearest neighbour, half coordinates
                      + zoom_pkg::addr_t'(y >> 1) * zoom_pkg::addr_t'(zoom_pkg::IMG_WIDTH)
                      + zoom_pkg::addr_t'(x >> 1);
        end else begin
            next_addr = src_base
                      + (zoom_pkg::addr_t'(y) << shift) * zoom_pkg::addr_t'(zoom_pkg::IMG_WIDTH)
                      + (zoom_pkg::addr_t'(x) << shift);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= s_idle;
            acc_req   <= 1'b0;
            acc_write <= 1'b0;
            finished  <= 1'b0;
            phase     <= 1'b0;
            x         <= '0;
            y         <= '0;
        end else begin
            finished <= 1'b0;
            case (state)
                s_idle: begin
                    if (start) begin
                        x     <= '0;
                        y     <= '0;
                        phase <= (kind == zoom_pkg::kind_single) ? factor_four : 1'b0;
                        state <= s_issue;
                    end
                end
                s_issue: begin
                    acc_req   <= 1'b1;
                    acc_write <= phase;
                    state     <= s_wait_hi;
                end
                s_wait_hi: begin
                    if (acc_ack) begin
                        acc_req <= 1'b0;
                        state   <= s_wait_lo;
                    end
                end
                s_wait_lo: begin
                    if (!acc_ack) state <= s_next;
                end
                s_next: begin
                    if (kind == zoom_pkg::kind_single || (phase && last_pixel)) begin
                        finished <= 1'b1;
                        state    <= s_idle;
                    end else begin
                        phase <= !phase;
                        if (phase) begin // write done so move to the next pixel
                            if (x == last_x) begin
                                x <= '0;
                                y <= y + 10'd1;
                            end else begin
                                x <= x + 10'd1;
                            end
                        end
                        state <= s_issue;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == s_issue) acc_addr <= next_addr;
    end

    ack_only_on_req: assert property (@(posedge clock) disable iff (reset)
        $rose(acc_ack) |-> acc_req);

endmodule

// ==== hw/zoom_cmd_decode.sv ====
module zoom_cmd_decode (
    input  logic               clock,
    input  logic               reset,
    input  logic               req,
    input  logic [2:0]         operation,
    input  logic               zoom_alt,
    input  zoom_pkg::addr_t    addr_base,
    input  logic               finished,
    output logic               ack,
    output logic               start,
    output zoom_pkg::op_kind_e kind,
    output logic               factor_four, // for a single access this is the write flag
    output zoom_pkg::addr_t    src_base,
    output zoom_pkg::addr_t    dst_base
);

    zoom_pkg::op_kind_e next_kind;
    logic               next_factor;
    zoom_pkg::addr_t    next_src;
    zoom_pkg::addr_t    next_dst;
    logic               busy;   // a command is running in the sequencer
    logic               accept;

    assign accept = req && !ack && !busy;

    always_comb begin
        next_kind   = zoom_pkg::kind_none;
        next_factor = 1'b0;
        next_src    = addr_base;
        next_dst    = addr_base;
        case (operation)
            zoom_pkg::op_read, zoom_pkg::op_write: begin
                next_kind   = zoom_pkg::kind_single;
                next_factor = (operation == zoom_pkg::op_write);
            end
            zoom_pkg::op_zoom_in: begin
                next_kind = zoom_pkg::kind_zoom_in;
                next_src  = zoom_alt ? zoom_pkg::ZOOM_IN_ALT_SRC_BASE : zoom_pkg::ZOOM_IN_SRC_BASE;
                next_dst  = zoom_alt ? zoom_pkg::ZOOM_IN_ALT_DST_BASE : zoom_pkg::ZOOM_IN_DST_BASE;
            end
            zoom_pkg::op_zoom_out: begin
                next_kind   = zoom_pkg::kind_zoom_out;
                next_factor = zoom_alt; // alternate selects decimation by four
                next_src    = zoom_pkg::SRC_BASE;
                next_dst    = zoom_pkg::DST_BASE;
            end
            default: next_kind = zoom_pkg::kind_none; // acked at once, no access
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ack   <= 1'b0;
            start <= 1'b0;
            busy  <= 1'b0;
        end else begin
            start <= 1'b0;
            if (accept) begin
                start <= (next_kind != zoom_pkg::kind_none);
                busy  <= (next_kind != zoom_pkg::kind_none);
                ack   <= (next_kind == zoom_pkg::kind_none);
            end else if (finished) begin
                busy <= 1'b0;
                ack  <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0; // four-phase release
            end
        end
    end

    // held for the whole command, the sequencer samples them on start
    always_ff @(posedge clock) begin
        if (accept) begin
            kind        <= next_kind;
            factor_four <= next_factor;
            src_base    <= next_src;
            dst_base    <= next_dst;
        end
    end

    ack_needs_req: assert property (@(posedge clock) disable iff (reset)
        $rose(ack) |-> req);

endmodule

// ==== hw/zoom_mem_ctrl.sv ====
module zoom_mem_ctrl (
    input  logic            clock,
    input  logic            reset,
    input  logic            req,
    input  logic [2:0]      operation,
    input  logic            zoom_alt,
    input  zoom_pkg::addr_t addr_base,
    output logic            ack,
    output zoom_pkg::addr_t mem_addr,
    output logic            mem_write,
    output logic            mem_busy
);

    logic               start;
    logic               finished;
    zoom_pkg::op_kind_e kind;
    logic               factor_four;
    zoom_pkg::addr_t    src_base;
    zoom_pkg::addr_t    dst_base;
    logic               acc_req;
    logic               acc_ack;
    zoom_pkg::addr_t    acc_addr;
    logic               acc_write;

    zoom_cmd_decode u_decode (
        .clock       (clock),
        .reset       (reset),
        .req         (req),
        .operation   (operation),
        .zoom_alt    (zoom_alt),
        .addr_base   (addr_base),
        .finished    (finished),
        .ack         (ack),
        .start       (start),
        .kind        (kind),
        .factor_four (factor_four),
        .src_base    (src_base),
        .dst_base    (dst_base)
    );

    zoom_addr_sequencer u_sequencer (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .kind        (kind),
        .factor_four (factor_four),
        .src_base    (src_base),
        .dst_base    (dst_base),
        .acc_ack     (acc_ack),
        .acc_req     (acc_req),
        .acc_addr    (acc_addr),
        .acc_write   (acc_write),
        .finished    (finished)
    );

    mem_access_timer u_timer (
        .clock     (clock),
        .reset     (reset),
        .acc_req   (acc_req),
        .acc_addr  (acc_addr),
        .acc_write (acc_write),
        .acc_ack   (acc_ack),
        .mem_addr  (mem_addr),
        .mem_write (mem_write),
        .mem_busy  (mem_busy)
    );

endmodule

// ==== hw/zoom_pkg.sv ====
package zoom_pkg;

    typedef logic [17:0] addr_t;  // frame-buffer word address
    typedef logic [9:0]  coord_t; // pixel column or row

    typedef enum logic [2:0] {
        op_read     = 3'd1,
        op_write    = 3'd2,
        op_zoom_in  = 3'd3,
        op_zoom_out = 3'd5
    } op_e;

    typedef enum logic [1:0] {
        kind_single,
        kind_zoom_in,
        kind_zoom_out,
        kind_none
    } op_kind_e;

    localparam coord_t IMG_WIDTH  = 10'd320;
    localparam coord_t IMG_HEIGHT = 10'd240;

    localparam addr_t SRC_BASE             = 18'd0;
    localparam addr_t DST_BASE             = 18'd96000;
    localparam addr_t ZOOM_IN_SRC_BASE     = 18'd19200;  // quarter-size image
    localparam addr_t ZOOM_IN_DST_BASE     = 18'd76800;
    localparam addr_t ZOOM_IN_ALT_SRC_BASE = 18'd96000;
    localparam addr_t ZOOM_IN_ALT_DST_BASE = 18'd153600;

    // decimation windows inside the destination frame
    localparam coord_t WIN2_X0 = 10'd80;
    localparam coord_t WIN2_Y0 = 10'd60;
    localparam coord_t WIN2_W  = 10'd160;
    localparam coord_t WIN2_H  = 10'd120;
    localparam coord_t WIN4_X0 = 10'd120;
    localparam coord_t WIN4_Y0 = 10'd90;
    localparam coord_t WIN4_W  = 10'd80;
    localparam coord_t WIN4_H  = 10'd60;

    localparam logic [2:0] ACCESS_CYCLES = 3'd4; // cycles each access is held

endpackage

// ==== zoom_mem_ctrl.f ====
hw/zoom_pkg.sv
hw/zoom_cmd_decode.sv
hw/zoom_addr_sequencer.sv
hw/mem_access_timer.sv
hw/zoom_mem_ctrl.sv
dv/zoom_mem_ctrl_tb.sv
